// File: hw/ip_rx_pkg.sv
/*
 * Shared types, widths and IPv4 header layout for the IP frame receiver.
 * Imported by every RTL module of the receiver.
 */
package ip_rx_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] ip_len_t;
    typedef logic [4:0]  hdr_ptr_t;

    // header without options
    localparam int IP_HDR_BYTES = 20;

    localparam logic [3:0] IP_VERSION_4 = 4'd4;
    localparam logic [3:0] IP_IHL_MIN   = 4'd5;

    // byte positions of the fields that are kept
    localparam hdr_ptr_t HDR_OFS_VER_IHL   = 5'd0;
    localparam hdr_ptr_t HDR_OFS_LEN_HI    = 5'd2;
    localparam hdr_ptr_t HDR_OFS_LEN_LO    = 5'd3;
    localparam hdr_ptr_t HDR_OFS_PROTO     = 5'd9;
    localparam hdr_ptr_t HDR_OFS_SRC_FIRST = 5'd12;
    localparam hdr_ptr_t HDR_OFS_DST_FIRST = 5'd16;

    // parser frame states
    typedef enum logic [2:0] {
        st_idle,
        st_header,
        st_payload,
        st_hold_last,
        st_drain
    } rx_state_e;

endpackage

// File: hw/ip_addr_classifier.sv
/*
 * Three-stage destination address classifier with the header output register.
 * Holds fields and flags on the header port until m_hdr_ready is seen.
 */
`timescale 1ns/1ns

module ip_addr_classifier
    import ip_rx_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     fields_done,
    input  ip_len_t  ip_length,
    input  byte_t    ip_protocol,
    input  ip_addr_t source_ip,
    input  ip_addr_t dest_ip,
    input  ip_addr_t gateway_ip,
    input  ip_addr_t subnet_mask,
    output logic     hdr_busy,
    output logic     m_hdr_valid,
    input  logic     m_hdr_ready,
    output ip_len_t  m_ip_length,
    output byte_t    m_ip_protocol,
    output ip_addr_t m_ip_source_ip,
    output ip_addr_t m_ip_dest_ip,
    output logic     m_is_broadcast,
    output logic     m_is_subnet_broadcast,
    output logic     m_is_local
);

    logic       v1, v2;
    logic [3:0] bcast_byte;
    ip_addr_t   dst_or_mask;
    ip_addr_t   dst_gw_masked;
    logic       bcast_all;
    logic [3:0] subnet_byte;
    logic [3:0] local_byte;

    // from the first stage until the header has been taken
    assign hdr_busy = v1 || v2 || m_hdr_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            v1          <= 1'b0;
            v2          <= 1'b0;
            m_hdr_valid <= 1'b0;
        end else begin
            v1 <= fields_done;
            v2 <= v1;
            if (v2) begin
                m_hdr_valid <= 1'b1;
            end else if (m_hdr_ready) begin
                m_hdr_valid <= 1'b0;
            end
        end

        // stage 1: byte compares and masking
        for (int i = 0; i < 4; i++) begin
            bcast_byte[i] <= (dest_ip[8*i +: 8] == 8'hff);
        end
        dst_or_mask   <= dest_ip | subnet_mask;
        dst_gw_masked <= (dest_ip ^ gateway_ip) & subnet_mask;

        // stage 2
        bcast_all <= &bcast_byte;
        for (int i = 0; i < 4; i++) begin
            subnet_byte[i] <= (dst_or_mask[8*i +: 8] == 8'hff);
            local_byte[i]  <= (dst_gw_masked[8*i +: 8] == 8'h00);
        end

        // stage 3 loads the output register
        if (v2) begin
            m_ip_length           <= ip_length;
            m_ip_protocol         <= ip_protocol;
            m_ip_source_ip        <= source_ip;
            m_ip_dest_ip          <= dest_ip;
            m_is_broadcast        <= bcast_all;
            m_is_subnet_broadcast <= &subnet_byte;
            m_is_local            <= &local_byte;
        end
    end

endmodule

// File: hw/ip_payload_skid.sv
/*
 * Two-entry skid buffer on the payload stream. Gives full throughput while the
 * upstream ready is registered one cycle ahead through pl_ready_early.
 */
`timescale 1ns/1ns

module ip_payload_skid
    import ip_rx_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  byte_t pl_data,
    input  logic  pl_valid,
    input  logic  pl_last,
    input  logic  pl_user,
    output logic  pl_ready_early,
    output byte_t m_data,
    output logic  m_valid,
    input  logic  m_ready,
    output logic  m_last,
    output logic  m_user
);

    logic  ready_int;
    logic  m_valid_next;
    byte_t tmp_data;
    logic  tmp_valid, tmp_valid_next;
    logic  tmp_last;
    logic  tmp_user;
    logic  in_to_out;
    logic  in_to_tmp;
    logic  tmp_to_out;

    // temp stays empty if output drains or nothing new comes in
    assign pl_ready_early = m_ready || (!tmp_valid && (!m_valid || !pl_valid));

    always_comb begin
        m_valid_next   = m_valid;
        tmp_valid_next = tmp_valid;
        in_to_out      = 1'b0;
        in_to_tmp      = 1'b0;
        tmp_to_out     = 1'b0;

        if (ready_int) begin
            if (m_ready || !m_valid) begin
                m_valid_next = pl_valid;
                in_to_out    = 1'b1;
            end else begin
                tmp_valid_next = pl_valid;
                in_to_tmp      = 1'b1;
            end
        end else if (m_ready) begin
            m_valid_next   = tmp_valid;
            tmp_valid_next = 1'b0;
            tmp_to_out     = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m_valid   <= 1'b0;
            tmp_valid <= 1'b0;
            ready_int <= 1'b0;
        end else begin
            m_valid   <= m_valid_next;
            tmp_valid <= tmp_valid_next;
            ready_int <= pl_ready_early;
        end

        if (in_to_out) begin
            m_data <= pl_data;
            m_last <= pl_last;
            m_user <= pl_user;
        end else if (tmp_to_out) begin
            m_data <= tmp_data;
            m_last <= tmp_last;
            m_user <= tmp_user;
        end

        if (in_to_tmp) begin
            tmp_data <= pl_data;
            tmp_last <= pl_last;
            tmp_user <= pl_user;
        end
    end

endmodule

// File: hw/ip_hdr_parser.sv
/*
 * Input side of the receiver: walks the IPv4 header of each frame, keeps the
 * needed fields, checks version and IHL, and trims the payload to its length.
 */
`timescale 1ns/1ns

module ip_hdr_parser
    import ip_rx_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  byte_t    s_data,
    input  logic     s_valid,
    output logic     s_ready,
    input  logic     s_last,
    input  logic     s_user,
    input  logic     hdr_busy,
    output logic     fields_done,
    output ip_len_t  ip_length,
    output byte_t    ip_protocol,
    output ip_addr_t source_ip,
    output ip_addr_t dest_ip,
    output byte_t    pl_data,
    output logic     pl_valid,
    output logic     pl_last,
    output logic     pl_user,
    input  logic     pl_ready_early,
    output logic     err_hdr_early,
    output logic     err_payload_early,
    output logic     err_bad_header
);

    localparam hdr_ptr_t HDR_PTR_LAST = hdr_ptr_t'(IP_HDR_BYTES - 1);

    rx_state_e state, state_next;
    hdr_ptr_t  hdr_ptr, hdr_ptr_next;
    ip_len_t   rem_cnt, rem_cnt_next;
    byte_t     ver_ihl;
    byte_t     last_byte;
    logic      store_last;
    logic      s_ready_next;
    logic      fields_done_next;
    logic      err_hdr_early_next;
    logic      err_payload_early_next;
    logic      err_bad_header_next;
    logic      xfer;
    logic      hdr_ok;

    assign xfer   = s_valid && s_ready;
    assign hdr_ok = (ver_ihl[7:4] == IP_VERSION_4) && (ver_ihl[3:0] == IP_IHL_MIN);

    always_comb begin
        state_next             = state;
        hdr_ptr_next           = hdr_ptr;
        rem_cnt_next           = rem_cnt;
        s_ready_next           = 1'b0;
        store_last             = 1'b0;
        fields_done_next       = 1'b0;
        err_hdr_early_next     = 1'b0;
        err_payload_early_next = 1'b0;
        err_bad_header_next    = 1'b0;

        pl_data  = s_data;
        pl_valid = 1'b0;
        pl_last  = s_last;
        pl_user  = s_user;

        case (state)
            st_idle: begin
                hdr_ptr_next = '0;
                // wait until the previous header has been taken
                if (!hdr_busy) begin
                    s_ready_next = 1'b1;
                    state_next   = st_header;
                end
            end
            st_header: begin
                s_ready_next = 1'b1;
                if (xfer) begin
                    hdr_ptr_next = hdr_ptr + 5'd1;
                    if (hdr_ptr == HDR_PTR_LAST) begin
                        if (hdr_ok) begin
                            fields_done_next = 1'b1;
                            rem_cnt_next     = ip_length - ip_len_t'(IP_HDR_BYTES);
                            s_ready_next     = pl_ready_early;
                            state_next       = st_payload;
                        end else begin
                            err_bad_header_next = 1'b1;
                            state_next          = st_drain;
                        end
                    end
                    // frame ended before the header was complete
                    if (s_last) begin
                        err_hdr_early_next = 1'b1;
                        fields_done_next   = 1'b0;
                        s_ready_next       = 1'b0;
                        state_next         = st_idle;
                    end
                end
            end
            st_payload: begin
                s_ready_next = pl_ready_early;
                pl_valid     = xfer;
                if (xfer) begin
                    rem_cnt_next = rem_cnt - 16'd1;
                    if (s_last) begin
                        if (rem_cnt > 16'd1) begin
                            pl_user                = 1'b1;
                            err_payload_early_next = 1'b1;
                        end
                        s_ready_next = 1'b0;
                        state_next   = st_idle;
                    end else if (rem_cnt <= 16'd1) begin
                        // padding follows, keep this byte until s_last
                        store_last = 1'b1;
                        pl_valid   = 1'b0;
                        state_next = st_hold_last;
                    end
                end
            end
            st_hold_last: begin
                s_ready_next = pl_ready_early;
                pl_data      = last_byte;
                pl_valid     = xfer && s_last;
                if (xfer && s_last) begin
                    s_ready_next = 1'b0;
                    state_next   = st_idle;
                end
            end
            st_drain: begin
                s_ready_next = 1'b1;
                if (xfer && s_last) begin
                    s_ready_next = 1'b0;
                    state_next   = st_idle;
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state             <= st_idle;
            hdr_ptr           <= '0;
            s_ready           <= 1'b0;
            fields_done       <= 1'b0;
            err_hdr_early     <= 1'b0;
            err_payload_early <= 1'b0;
            err_bad_header    <= 1'b0;
        end else begin
            state             <= state_next;
            hdr_ptr           <= hdr_ptr_next;
            s_ready           <= s_ready_next;
            fields_done       <= fields_done_next;
            err_hdr_early     <= err_hdr_early_next;
            err_payload_early <= err_payload_early_next;
            err_bad_header    <= err_bad_header_next;
        end

        rem_cnt <= rem_cnt_next;

        if (store_last) begin
            last_byte <= s_data;
        end

        // field capture, addresses shift in msb first
        if (state == st_header && xfer) begin
            if (hdr_ptr == HDR_OFS_VER_IHL) ver_ihl <= s_data;
            if (hdr_ptr == HDR_OFS_LEN_HI) ip_length[15:8] <= s_data;
            if (hdr_ptr == HDR_OFS_LEN_LO) ip_length[7:0] <= s_data;
            if (hdr_ptr == HDR_OFS_PROTO) ip_protocol <= s_data;
            if (hdr_ptr >= HDR_OFS_SRC_FIRST && hdr_ptr < HDR_OFS_SRC_FIRST + 5'd4) begin
                source_ip <= {source_ip[23:0], s_data};
            end
            if (hdr_ptr >= HDR_OFS_DST_FIRST && hdr_ptr < HDR_OFS_DST_FIRST + 5'd4) begin
                dest_ip <= {dest_ip[23:0], s_data};
            end
        end
    end

endmodule

// File: hw/ip_rx_top.sv
/*
 * IPv4 frame receiver: byte stream in, header fields and trimmed payload out.
 */
`timescale 1ns/1ns

module ip_rx_top
    import ip_rx_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  byte_t    s_data,
    input  logic     s_valid,
    output logic     s_ready,
    input  logic     s_last,
    input  logic     s_user,
    output logic     m_hdr_valid,
    input  logic     m_hdr_ready,
    output ip_len_t  m_ip_length,
    output byte_t    m_ip_protocol,
    output ip_addr_t m_ip_source_ip,
    output ip_addr_t m_ip_dest_ip,
    output logic     m_is_broadcast,
    output logic     m_is_subnet_broadcast,
    output logic     m_is_local,
    output byte_t    m_data,
    output logic     m_valid,
    input  logic     m_ready,
    output logic     m_last,
    output logic     m_user,
    input  ip_addr_t gateway_ip,
    input  ip_addr_t subnet_mask,
    output logic     err_hdr_early,
    output logic     err_payload_early,
    output logic     err_bad_header
);

    // parser to classifier
    logic     fields_done;
    logic     hdr_busy;
    ip_len_t  ip_length;
    byte_t    ip_protocol;
    ip_addr_t source_ip;
    ip_addr_t dest_ip;

    // parser to skid buffer
    byte_t pl_data;
    logic  pl_valid;
    logic  pl_last;
    logic  pl_user;
    logic  pl_ready_early;

    ip_hdr_parser u_parser (
        .clk               (clk),
        .rst               (rst),
        .s_data            (s_data),
        .s_valid           (s_valid),
        .s_ready           (s_ready),
        .s_last            (s_last),
        .s_user            (s_user),
        .hdr_busy          (hdr_busy),
        .fields_done       (fields_done),
        .ip_length         (ip_length),
        .ip_protocol       (ip_protocol),
        .source_ip         (source_ip),
        .dest_ip           (dest_ip),
        .pl_data           (pl_data),
        .pl_valid          (pl_valid),
        .pl_last           (pl_last),
        .pl_user           (pl_user),
        .pl_ready_early    (pl_ready_early),
        .err_hdr_early     (err_hdr_early),
        .err_payload_early (err_payload_early),
        .err_bad_header    (err_bad_header)
    );

    ip_addr_classifier u_classifier (
        .clk                   (clk),
        .rst                   (rst),
        .fields_done           (fields_done),
        .ip_length             (ip_length),
        .ip_protocol           (ip_protocol),
        .source_ip             (source_ip),
        .dest_ip               (dest_ip),
        .gateway_ip            (gateway_ip),
        .subnet_mask           (subnet_mask),
        .hdr_busy              (hdr_busy),
        .m_hdr_valid           (m_hdr_valid),
        .m_hdr_ready           (m_hdr_ready),
        .m_ip_length           (m_ip_length),
        .m_ip_protocol         (m_ip_protocol),
        .m_ip_source_ip        (m_ip_source_ip),
        .m_ip_dest_ip          (m_ip_dest_ip),
        .m_is_broadcast        (m_is_broadcast),
        .m_is_subnet_broadcast (m_is_subnet_broadcast),
        .m_is_local            (m_is_local)
    );

    ip_payload_skid u_skid (
        .clk            (clk),
        .rst            (rst),
        .pl_data        (pl_data),
        .pl_valid       (pl_valid),
        .pl_last        (pl_last),
        .pl_user        (pl_user),
        .pl_ready_early (pl_ready_early),
        .m_data         (m_data),
        .m_valid        (m_valid),
        .m_ready        (m_ready),
        .m_last         (m_last),
        .m_user         (m_user)
    );

endmodule

// File: verification/ip_rx_tb.sv
/*
 * Self-checking testbench for the IPv4 frame receiver. Sends directed and random
 * frames, queues the expected header and payload, and checks them with assertions.
 */
`timescale 1ns/1ns

module ip_rx_tb
    import ip_rx_pkg::*;
();

    localparam int CLK_HALF       = 5;
    localparam int N_DIRECTED     = 10;
    localparam int N_RANDOM       = 14;
    localparam int N_FRAMES       = N_DIRECTED + N_RANDOM;
    localparam int TIMEOUT_CYCLES = N_FRAMES * 200 + 1000;

    logic     clk;
    logic     rst;
    byte_t    s_data;
    logic     s_valid;
    logic     s_ready;
    logic     s_last;
    logic     s_user;
    logic     m_hdr_valid;
    logic     m_hdr_ready;
    ip_len_t  m_ip_length;
    byte_t    m_ip_protocol;
    ip_addr_t m_ip_source_ip;
    ip_addr_t m_ip_dest_ip;
    logic     m_is_broadcast;
    logic     m_is_subnet_broadcast;
    logic     m_is_local;
    byte_t    m_data;
    logic     m_valid;
    logic     m_ready;
    logic     m_last;
    logic     m_user;
    ip_addr_t gateway_ip;
    ip_addr_t subnet_mask;
    logic     err_hdr_early;
    logic     err_payload_early;
    logic     err_bad_header;

    // expected header {length, protocol, src, dst, bcast, subnet bcast, local}
    logic [90:0] hdr_q[$];
    // expected payload {user, last, data}
    logic [9:0]  pay_q[$];
    logic [90:0] got_hdr;
    logic [90:0] exp_hdr;
    logic [9:0]  got_pay;
    logic [9:0]  exp_pay;
    logic        stall_en;
    int          exp_hdr_early;
    int          exp_payload_early;
    int          exp_bad_header;
    int          act_hdr_early;
    int          act_payload_early;
    int          act_bad_header;

    ip_rx_top u_dut (
        .clk                   (clk),
        .rst                   (rst),
        .s_data                (s_data),
        .s_valid               (s_valid),
        .s_ready               (s_ready),
        .s_last                (s_last),
        .s_user                (s_user),
        .m_hdr_valid           (m_hdr_valid),
        .m_hdr_ready           (m_hdr_ready),
        .m_ip_length           (m_ip_length),
        .m_ip_protocol         (m_ip_protocol),
        .m_ip_source_ip        (m_ip_source_ip),
        .m_ip_dest_ip          (m_ip_dest_ip),
        .m_is_broadcast        (m_is_broadcast),
        .m_is_subnet_broadcast (m_is_subnet_broadcast),
        .m_is_local            (m_is_local),
        .m_data                (m_data),
        .m_valid               (m_valid),
        .m_ready               (m_ready),
        .m_last                (m_last),
        .m_user                (m_user),
        .gateway_ip            (gateway_ip),
        .subnet_mask           (subnet_mask),
        .err_hdr_early         (err_hdr_early),
        .err_payload_early     (err_payload_early),
        .err_bad_header        (err_bad_header)
    );

    assign got_hdr = {m_ip_length, m_ip_protocol, m_ip_source_ip, m_ip_dest_ip,
                      m_is_broadcast, m_is_subnet_broadcast, m_is_local};
    assign got_pay = {m_user, m_last, m_data};

    always #CLK_HALF clk = ~clk;

    task automatic mismatch_stop(input string msg);
        $display("Fail at %0t ns: %s", $time, msg);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1);
    endtask

    // one byte on the input stream held until s_ready was high at the edge
    task automatic drive_byte(input byte_t data, input logic last);
        logic taken;
        taken   = 1'b0;
        s_data  = data;
        s_valid = 1'b1;
        s_last  = last;
        while (!taken) begin
            @(negedge clk);
            taken = s_ready;
            @(posedge clk);
            #1;
        end
        s_valid = 1'b0;
        s_last  = 1'b0;
    endtask

    // builds the frame, queues what should come out, then sends total bytes
    task automatic send_frame(input byte_t ver_ihl, input ip_len_t len, input byte_t proto,
                              input ip_addr_t src, input ip_addr_t dst, input int total);
        byte_t frame[$];
        int    pay_len;
        int    n_pay;
        int    last_i;
        frame.push_back(ver_ihl);
        frame.push_back(byte_t'($urandom));
        frame.push_back(len[15:8]);
        frame.push_back(len[7:0]);
        // id, flags, fragment offset and ttl are skipped by the DUT
        for (int i = 4; i < 9; i++) begin
            frame.push_back(byte_t'($urandom));
        end
        frame.push_back(proto);
        frame.push_back(byte_t'($urandom));
        frame.push_back(byte_t'($urandom));
        for (int i = 3; i >= 0; i--) begin
            frame.push_back(src[8*i +: 8]);
        end
        for (int i = 3; i >= 0; i--) begin
            frame.push_back(dst[8*i +: 8]);
        end
        while (frame.size() < total) begin
            frame.push_back(byte_t'($urandom));
        end

        pay_len = int'(len) - IP_HDR_BYTES;
        n_pay   = total - IP_HDR_BYTES;
        last_i  = (n_pay < pay_len) ? n_pay - 1 : pay_len - 1;
        if (total <= IP_HDR_BYTES) begin
            exp_hdr_early++;
        end else if (ver_ihl != {IP_VERSION_4, IP_IHL_MIN}) begin
            exp_bad_header++;
        end else begin
            hdr_q.push_back({len, proto, src, dst, dst == 32'hffff_ffff,
                             (dst | subnet_mask) == 32'hffff_ffff,
                             ((dst ^ gateway_ip) & subnet_mask) == 32'h0});
            for (int i = 0; i <= last_i; i++) begin
                pay_q.push_back({n_pay < pay_len && i == last_i, i == last_i,
                                 frame[IP_HDR_BYTES + i]});
            end
            if (n_pay < pay_len) begin
                exp_payload_early++;
            end
        end

        for (int i = 0; i < total; i++) begin
            drive_byte(frame[i], i == total - 1);
        end
    endtask

    // exact, padded or cut short frame with a destination near the gateway subnet
    task automatic send_random_frame();
        int       pay_len;
        int       total;
        ip_addr_t dst;
        pay_len = 1 + int'($urandom % 40);
        total   = IP_HDR_BYTES + pay_len;
        case ($urandom % 4)
            2: total = total + 1 + int'($urandom % 6);
            3: if (pay_len > 1) total = IP_HDR_BYTES + 1 + int'($urandom % (pay_len - 1));
            default: ;
        endcase
        case ($urandom % 3)
            0: dst = (gateway_ip & subnet_mask) | (~subnet_mask & $urandom);
            1: dst = $urandom;
            default: dst = 32'hffff_ffff;
        endcase
        send_frame(8'h45, ip_len_t'(IP_HDR_BYTES + pay_len), byte_t'($urandom), $urandom,
                   dst, total);
    endtask

    // random back-pressure on both output ports
    always @(posedge clk) begin
        #1;
        if (stall_en) begin
            m_ready     = ($urandom % 2) == 0;
            m_hdr_ready = ($urandom % 3) == 0;
        end else begin
            m_ready     = 1'b1;
            m_hdr_ready = 1'b1;
        end
    end

    // handshakes seen at the falling edge complete on the next rising edge
    always @(negedge clk) begin
        if (!rst) begin
            if (m_hdr_valid && m_hdr_ready) begin
                assert (hdr_q.size() != 0)
                    else abort_run("header handshake when no header was expected");
                exp_hdr = hdr_q.pop_front();
                assert (got_hdr == exp_hdr)
                    else mismatch_stop($sformatf("header %h, expected %h", got_hdr, exp_hdr));
            end
            if (m_valid && m_ready) begin
                assert (pay_q.size() != 0)
                    else abort_run("payload byte when no byte was expected");
                exp_pay = pay_q.pop_front();
                assert (got_pay == exp_pay)
                    else mismatch_stop($sformatf("payload %h, expected %h", got_pay, exp_pay));
            end
            if (err_hdr_early) act_hdr_early++;
            if (err_payload_early) act_payload_early++;
            if (err_bad_header) act_bad_header++;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        m_valid && !m_ready |=> m_valid && $stable(got_pay))
        else abort_run("payload valid dropped or data changed while stalled");

    assert property (@(posedge clk) disable iff (rst)
        m_hdr_valid && !m_hdr_ready |=> m_hdr_valid && $stable(got_hdr))
        else abort_run("header valid dropped or fields changed while stalled");

    assert property (@(posedge clk) disable iff (rst) err_hdr_early |=> !err_hdr_early)
        else abort_run("err_hdr_early longer than one cycle");
    assert property (@(posedge clk) disable iff (rst) err_payload_early |=> !err_payload_early)
        else abort_run("err_payload_early longer than one cycle");
    assert property (@(posedge clk) disable iff (rst) err_bad_header |=> !err_bad_header)
        else abort_run("err_bad_header longer than one cycle");

    initial begin
        #(TIMEOUT_CYCLES * 2 * CLK_HALF);
        abort_run("timeout, the receiver stopped making progress");
    end

    initial begin
        void'($urandom(74581));
        clk               = 1'b0;
        rst               = 1'b1;
        s_data            = '0;
        s_valid           = 1'b0;
        s_last            = 1'b0;
        s_user            = 1'b0;
        m_ready           = 1'b1;
        m_hdr_ready       = 1'b1;
        gateway_ip        = 32'hc0a8_0101;
        subnet_mask       = 32'hffff_ff00;
        stall_en          = 1'b0;
        exp_hdr_early     = 0;
        exp_payload_early = 0;
        exp_bad_header    = 0;
        act_hdr_early     = 0;
        act_payload_early = 0;
        act_bad_header    = 0;

        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        assert (!s_ready && !m_hdr_valid && !m_valid && !u_dut.hdr_busy && !err_hdr_early
                && !err_payload_early && !err_bad_header)
            else abort_run("outputs not low after reset");
        @(posedge clk);
        #1;

        // plain frame then one with padding behind the payload
        send_frame(8'h45, 16'd36, 8'h11, 32'h0a00_0001, 32'hc0a8_0114, 36);
        send_frame(8'h45, 16'd25, 8'h06, 32'h0a00_0002, 32'hc0a8_0115, 32);
        // bad headers interleaved with the address flag frames
        send_frame(8'h65, 16'd30, 8'h11, 32'h0a00_0003, 32'hc0a8_0116, 30);
        send_frame(8'h45, 16'd28, 8'h11, 32'h0a00_0004, 32'hffff_ffff, 28);
        send_frame(8'h46, 16'd30, 8'h11, 32'h0a00_0005, 32'hc0a8_0117, 30);
        send_frame(8'h45, 16'd24, 8'h01, 32'h0a00_0006, 32'hc0a8_01ff, 24);
        // s_last inside the header
        send_frame(8'h45, 16'd40, 8'h06, 32'h0a00_0007, 32'hc0a8_0118, 13);
        send_frame(8'h45, 16'd22, 8'h11, 32'h0a00_0008, 32'hc0a8_0142, 22);
        // s_last inside the payload
        send_frame(8'h45, 16'd40, 8'h06, 32'h0a00_0009, 32'hc0a8_0119, 27);
        send_frame(8'h45, 16'd23, 8'h11, 32'h0a00_000a, 32'h0a01_0203, 23);

        stall_en = 1'b1;
        repeat (N_RANDOM) send_random_frame();
        stall_en = 1'b0;

        while (hdr_q.size() != 0 || pay_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (20) @(posedge clk);

        if (act_hdr_early == exp_hdr_early && act_payload_early == exp_payload_early
            && act_bad_header == exp_bad_header) begin
            $display("** PASS **");
            $finish;
        end else begin
            mismatch_stop($sformatf("error pulses hdr %0d/%0d payload %0d/%0d bad %0d/%0d",
                                    act_hdr_early, exp_hdr_early, act_payload_early,
                                    exp_payload_early, act_bad_header, exp_bad_header));
        end
    end

endmodule

// File: build.f
hw/ip_rx_pkg.sv
hw/ip_addr_classifier.sv
hw/ip_payload_skid.sv
hw/ip_hdr_parser.sv
hw/ip_rx_top.sv
verification/ip_rx_tb.sv

// File: Makefile
# Verilator build and run for the IPv4 frame receiver testbench
# Variables can be overridden on the command line, e.g. make run OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= ip_rx_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_TEXT ?= ** PASS **

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# pass or fail comes from the pass message in the simulation output
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	if echo "$$out" | grep -qF '$(PASS_TEXT)'; then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR)
